//--- hdl/fsrc_ctrl_if.sv
// *********************************************************************
// Converter control interface
// Carries the programmed settings and one-cycle control pulses from
// the register block to the phase accumulator and the datapath
// *********************************************************************

interface fsrc_ctrl_if;

  // Static settings, held until rewritten
  logic                  enable;
  fsrc_pkg::chan_mask_t  conv_mask;
  fsrc_pkg::phase_t      step;
  fsrc_pkg::phase_t      set_phase;

  // Pulses, each high for a single clock cycle
  logic                  start;
  logic                  stop;
  logic                  phase_load;

  // The register block owns every signal
  modport regs (
    output enable, conv_mask, step, set_phase,
    output start, stop, phase_load
  );

  // Accumulator and datapath only observe the settings
  modport user (
    input enable, conv_mask, step, set_phase,
    input start, stop, phase_load
  );

endinterface

//--- hdl/fsrc_phase_accum.sv
// *********************************************************************
// Converter run control and phase accumulator
// Tracks the running state, steps the phase on every emitted beat and
// flags the beats that must be inserted
// *********************************************************************

module fsrc_phase_accum (
  input  logic                clk,
  input  logic                reset,
  fsrc_ctrl_if.user           ctrl,
  input  logic                beat_taken,
  output logic                running,
  output logic                insert,
  output fsrc_pkg::count_t    insert_count
);

  typedef enum logic {
    IDLE,
    RUN
  } run_state_t;

  run_state_t                         state;
  fsrc_pkg::phase_t                   phase;
  // One extra bit holds the carry out of the phase addition
  logic [fsrc_pkg::PHASE_WIDTH:0]     phase_sum;

  // *******************************************************************
  // Run state
  // *******************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (ctrl.start && ctrl.enable) state <= RUN;
        // Dropping enable stops the converter just like a stop pulse
        RUN:  if (ctrl.stop || !ctrl.enable) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign running = (state == RUN);

  // *******************************************************************
  // Phase and insertion
  // *******************************************************************

  assign phase_sum = {1'b0, phase} + {1'b0, ctrl.step};

  // An overflow on the next step means the next loaded beat is an extra one
  assign insert = running && phase_sum[fsrc_pkg::PHASE_WIDTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else if (ctrl.phase_load) begin
      phase <= ctrl.set_phase;
    end else if (beat_taken) begin
      phase <= phase_sum[fsrc_pkg::PHASE_WIDTH-1:0];
    end
  end

  // Counter restarts with every start pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      insert_count <= '0;
    end else if (ctrl.start) begin
      insert_count <= '0;
    end else if (beat_taken && insert) begin
      insert_count <= insert_count + 1'b1;
    end
  end

  // The datapath only loads beats while running, so insertions stay inside RUN
  assert property (@(posedge clk) disable iff (reset)
    (insert || beat_taken) |-> state == RUN);

endmodule

//--- hdl/fsrc_pkg.sv
// *********************************************************************
// Fractional sample rate converter shared definitions
// Widths, typedefs, register map and constant words used by the
// transmit-side converter blocks
// *********************************************************************

package fsrc_pkg;

  // *******************************************************************
  // Widths
  // *******************************************************************

  localparam int NUM_CHANNELS = 4;
  localparam int SAMPLE_WIDTH = 16;
  localparam int BEAT_WIDTH   = NUM_CHANNELS * SAMPLE_WIDTH;
  localparam int PHASE_WIDTH  = 32;
  localparam int COUNT_WIDTH  = 32;
  localparam int ADDR_WIDTH   = 8;
  localparam int DATA_WIDTH   = 32;

  // One channel sample and a full stream beat, channel 0 in the low bits
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [BEAT_WIDTH-1:0]   beat_t;
  typedef logic [NUM_CHANNELS-1:0] chan_mask_t;
  typedef logic [PHASE_WIDTH-1:0]  phase_t;
  typedef logic [COUNT_WIDTH-1:0]  count_t;
  typedef logic [ADDR_WIDTH-1:0]   reg_addr_t;
  typedef logic [DATA_WIDTH-1:0]   reg_data_t;

  // Version is major in the upper half, then minor and patch bytes
  localparam reg_data_t CORE_VERSION = {16'h0001, 8'h00, 8'h00};
  // ASCII "FSRC"
  localparam reg_data_t CORE_MAGIC   = 32'h4653_5243;

  // Sample placed in the masked channels of an inserted beat
  localparam sample_t FILL_SAMPLE = '0;

  // *******************************************************************
  // Register map, word addresses
  // *******************************************************************

  localparam reg_addr_t ADDR_VERSION      = 8'h00;
  localparam reg_addr_t ADDR_MAGIC        = 8'h01;
  localparam reg_addr_t ADDR_CONTROL      = 8'h02;
  localparam reg_addr_t ADDR_START        = 8'h03;
  localparam reg_addr_t ADDR_STOP         = 8'h04;
  localparam reg_addr_t ADDR_CONV_MASK    = 8'h05;
  localparam reg_addr_t ADDR_STEP         = 8'h06;
  localparam reg_addr_t ADDR_SET_PHASE    = 8'h07;
  localparam reg_addr_t ADDR_PHASE_LOAD   = 8'h08;
  localparam reg_addr_t ADDR_STATUS       = 8'h09;
  localparam reg_addr_t ADDR_INSERT_COUNT = 8'h0A;

  // Bit positions inside the control and status words
  localparam int CTRL_ENABLE_BIT    = 0;
  localparam int CTRL_EXT_TRIG_BIT  = 1;
  localparam int STATUS_RUNNING_BIT = 0;

endpackage

//--- hdl/fsrc_regmap.sv
// *********************************************************************
// Converter register block
// Decodes register writes into settings and control pulses, combines
// the external start pin with the start register and answers reads
// *********************************************************************

module fsrc_regmap (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  up_bus_if.slave             bus,
  fsrc_ctrl_if.regs           ctrl,
  input  logic                running,
  input  fsrc_pkg::count_t    insert_count
);

  // External trigger gate for the start pin
  logic                 ext_trig_en;
  // Start pulse produced by a register write
  logic                 start_wr_q;
  // Read mux result, registered onto the bus
  fsrc_pkg::reg_data_t  read_data;

  // *******************************************************************
  // Write decode
  // *******************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl.enable     <= 1'b0;
      ext_trig_en     <= 1'b0;
      ctrl.conv_mask  <= '0;
      ctrl.step       <= '0;
      ctrl.set_phase  <= '0;
      start_wr_q      <= 1'b0;
      ctrl.stop       <= 1'b0;
      ctrl.phase_load <= 1'b0;
      bus.wack        <= 1'b0;
    end else begin
      // Pulses drop back to zero unless written again this cycle
      start_wr_q      <= 1'b0;
      ctrl.stop       <= 1'b0;
      ctrl.phase_load <= 1'b0;
      bus.wack        <= bus.wreq;
      if (bus.wreq) begin
        case (bus.waddr)
          fsrc_pkg::ADDR_CONTROL: begin
            ctrl.enable <= bus.wdata[fsrc_pkg::CTRL_ENABLE_BIT];
            ext_trig_en <= bus.wdata[fsrc_pkg::CTRL_EXT_TRIG_BIT];
          end
          fsrc_pkg::ADDR_START:      start_wr_q      <= bus.wdata[0];
          fsrc_pkg::ADDR_STOP:       ctrl.stop       <= bus.wdata[0];
          fsrc_pkg::ADDR_CONV_MASK:  ctrl.conv_mask  <= bus.wdata[fsrc_pkg::NUM_CHANNELS-1:0];
          fsrc_pkg::ADDR_STEP:       ctrl.step       <= bus.wdata;
          fsrc_pkg::ADDR_SET_PHASE:  ctrl.set_phase  <= bus.wdata;
          fsrc_pkg::ADDR_PHASE_LOAD: ctrl.phase_load <= bus.wdata[0];
          // Read-only and unknown addresses ignore writes
          default: ;
        endcase
      end
    end
  end

  // The pin acts directly, a register start arrives one cycle after its write
  assign ctrl.start = start_wr_q | (start & ext_trig_en);

  // *******************************************************************
  // Read path
  // *******************************************************************

  always_comb begin
    read_data = '0;
    case (bus.raddr)
      fsrc_pkg::ADDR_VERSION: read_data = fsrc_pkg::CORE_VERSION;
      fsrc_pkg::ADDR_MAGIC:   read_data = fsrc_pkg::CORE_MAGIC;
      fsrc_pkg::ADDR_CONTROL: begin
        read_data[fsrc_pkg::CTRL_ENABLE_BIT]   = ctrl.enable;
        read_data[fsrc_pkg::CTRL_EXT_TRIG_BIT] = ext_trig_en;
      end
      fsrc_pkg::ADDR_CONV_MASK: read_data = fsrc_pkg::reg_data_t'(ctrl.conv_mask);
      fsrc_pkg::ADDR_STEP:      read_data = ctrl.step;
      fsrc_pkg::ADDR_SET_PHASE: read_data = ctrl.set_phase;
      fsrc_pkg::ADDR_STATUS:    read_data[fsrc_pkg::STATUS_RUNNING_BIT] = running;
      fsrc_pkg::ADDR_INSERT_COUNT: read_data = insert_count;
      // Pulse registers and unmapped words read as zero
      default: read_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bus.rack <= 1'b0;
    end else begin
      bus.rack <= bus.rreq;
    end
  end

  // Read data only changes on a request and is held until the next one
  always_ff @(posedge clk) begin
    if (bus.rreq) begin
      bus.rdata <= read_data;
    end
  end

  // *******************************************************************
  // Checks
  // *******************************************************************

  // Every request is acknowledged on the following cycle
  assert property (@(posedge clk) disable iff (reset)
    (bus.wreq |=> bus.wack) and (bus.rreq |=> bus.rack));

endmodule

//--- hdl/fsrc_tx.sv
// *********************************************************************
// Transmit-side fractional sample rate converter, top level
// Maps the stream, start and register ports onto the internal blocks
// *********************************************************************

module fsrc_tx (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,

  input  logic                  s_axis_valid,
  output logic                  s_axis_ready,
  input  fsrc_pkg::beat_t       s_axis_data,

  output logic                  m_axis_valid,
  input  logic                  m_axis_ready,
  output fsrc_pkg::beat_t       m_axis_data,

  input  logic                  up_wreq,
  input  fsrc_pkg::reg_addr_t   up_waddr,
  input  fsrc_pkg::reg_data_t   up_wdata,
  output logic                  up_wack,
  input  logic                  up_rreq,
  input  fsrc_pkg::reg_addr_t   up_raddr,
  output fsrc_pkg::reg_data_t   up_rdata,
  output logic                  up_rack
);

  logic               running;
  logic               insert;
  logic               beat_taken;
  fsrc_pkg::count_t   insert_count;

  up_bus_if     up_bus ();
  fsrc_ctrl_if  ctrl ();

  // Register ports drive the bus as its master
  assign up_bus.wreq  = up_wreq;
  assign up_bus.waddr = up_waddr;
  assign up_bus.wdata = up_wdata;
  assign up_bus.rreq  = up_rreq;
  assign up_bus.raddr = up_raddr;
  assign up_wack      = up_bus.wack;
  assign up_rdata     = up_bus.rdata;
  assign up_rack      = up_bus.rack;

  fsrc_regmap regmap_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .bus          (up_bus.slave),
    .ctrl         (ctrl.regs),
    .running      (running),
    .insert_count (insert_count)
  );

  fsrc_phase_accum phase_accum_i (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl.user),
    .beat_taken   (beat_taken),
    .running      (running),
    .insert       (insert),
    .insert_count (insert_count)
  );

  fsrc_tx_core core_i (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl.user),
    .running    (running),
    .insert     (insert),
    .beat_taken (beat_taken),
    .in_valid   (s_axis_valid),
    .in_ready   (s_axis_ready),
    .in_data    (s_axis_data),
    .out_valid  (m_axis_valid),
    .out_ready  (m_axis_ready),
    .out_data   (m_axis_data)
  );

endmodule

//--- hdl/fsrc_tx_core.sv
// *********************************************************************
// Converter stream datapath
// Accepts input beats, builds inserted beats from the mask and fill
// value, and holds the result in a single output register
// *********************************************************************

module fsrc_tx_core (
  input  logic                clk,
  input  logic                reset,
  fsrc_ctrl_if.user           ctrl,
  input  logic                running,
  input  logic                insert,
  output logic                beat_taken,
  input  logic                in_valid,
  output logic                in_ready,
  input  fsrc_pkg::beat_t     in_data,
  output logic                out_valid,
  input  logic                out_ready,
  output fsrc_pkg::beat_t     out_data
);

  // Input side is held off until the cycle after reset is released
  logic              ready_q;
  // Output register may take a new beat this cycle
  logic              load_en;
  // Converter active, as opposed to bypass
  logic              active;
  logic              load_insert;
  logic              in_take;
  fsrc_pkg::beat_t   fill_beat;

  always_ff @(posedge clk) begin
    if (reset) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  // *******************************************************************
  // Load control
  // *******************************************************************

  // Register is free when empty or when its beat leaves this cycle
  assign load_en = !out_valid || out_ready;
  assign active  = ctrl.enable && running;

  // Bypass passes input straight on, an enabled but stopped core takes nothing
  assign in_ready = ready_q && load_en && (!ctrl.enable || (running && !insert));

  assign in_take     = in_valid && in_ready;
  assign load_insert = load_en && active && insert;

  // Phase only advances on beats loaded while the converter runs
  assign beat_taken = active && (load_insert || in_take);

  // *******************************************************************
  // Inserted beat
  // *******************************************************************

  // The output register still holds the last loaded beat after it leaves
  always_comb begin
    for (int ch = 0; ch < fsrc_pkg::NUM_CHANNELS; ch++) begin
      if (ctrl.conv_mask[ch]) begin
        fill_beat[ch*fsrc_pkg::SAMPLE_WIDTH +: fsrc_pkg::SAMPLE_WIDTH] = fsrc_pkg::FILL_SAMPLE;
      end else begin
        fill_beat[ch*fsrc_pkg::SAMPLE_WIDTH +: fsrc_pkg::SAMPLE_WIDTH] =
          out_data[ch*fsrc_pkg::SAMPLE_WIDTH +: fsrc_pkg::SAMPLE_WIDTH];
      end
    end
  end

  // *******************************************************************
  // Output register
  // *******************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (load_en) begin
      out_valid <= load_insert || in_take;
    end
  end

  always_ff @(posedge clk) begin
    if (load_insert) begin
      out_data <= fill_beat;
    end else if (in_take) begin
      out_data <= in_data;
    end
  end

  // *******************************************************************
  // Checks
  // *******************************************************************

  // A stalled beat stays on the output unchanged
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

  // Input is only accepted when the register is free and no extra beat is due
  assert property (@(posedge clk) disable iff (reset)
    in_ready |-> (!out_valid || out_ready) && !load_insert);

endmodule

//--- hdl/up_bus_if.sv
// *********************************************************************
// Register request and acknowledge bus
// Single-cycle write and read requests, each acknowledged one cycle
// later, with read data valid alongside the read acknowledge
// *********************************************************************

interface up_bus_if;

  // Write channel
  logic                  wreq;
  fsrc_pkg::reg_addr_t   waddr;
  fsrc_pkg::reg_data_t   wdata;
  logic                  wack;

  // Read channel, independent of the write channel
  logic                  rreq;
  fsrc_pkg::reg_addr_t   raddr;
  fsrc_pkg::reg_data_t   rdata;
  logic                  rack;

  modport master (
    output wreq, waddr, wdata, rreq, raddr,
    input  wack, rdata, rack
  );

  modport slave (
    input  wreq, waddr, wdata, rreq, raddr,
    output wack, rdata, rack
  );

endinterface

//--- sim.f
hdl/fsrc_pkg.sv
hdl/fsrc_ctrl_if.sv
hdl/up_bus_if.sv
hdl/fsrc_regmap.sv
hdl/fsrc_phase_accum.sv
hdl/fsrc_tx_core.sv
hdl/fsrc_tx.sv
verification/fsrc_tx_checks.sv
verification/fsrc_tx_tb.sv

//--- verification/fsrc_tx_checks.sv
// *********************************************************************
// Converter reference model and checkers
// Follows registers, run state, phase and the output register from
// the port activity and compares the DUT ports every cycle
// *********************************************************************

module fsrc_tx_checks (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  s_axis_valid,
  input  logic                  s_axis_ready,
  input  fsrc_pkg::beat_t       s_axis_data,
  input  logic                  m_axis_valid,
  input  logic                  m_axis_ready,
  input  fsrc_pkg::beat_t       m_axis_data,
  input  logic                  up_wreq,
  input  fsrc_pkg::reg_addr_t   up_waddr,
  input  fsrc_pkg::reg_data_t   up_wdata,
  input  logic                  up_wack,
  input  logic                  up_rreq,
  input  fsrc_pkg::reg_addr_t   up_raddr,
  input  fsrc_pkg::reg_data_t   up_rdata,
  input  logic                  up_rack,
  output int                    errors,
  output int                    passes
);
  timeunit 1ns;
  timeprecision 100ps;

  // Register state as written over the bus
  logic                  enable_m;
  logic                  ext_trig_m;
  fsrc_pkg::chan_mask_t  mask_m;
  fsrc_pkg::phase_t      step_m;
  fsrc_pkg::phase_t      set_phase_m;
  // Pulses appear one cycle after their write
  logic                  start_wr_m;
  logic                  stop_m;
  logic                  phase_load_m;
  logic                  run_m;
  logic                  ready_q_m;
  fsrc_pkg::phase_t      phase_m;
  fsrc_pkg::count_t      count_m;
  logic                  wack_m;
  logic                  rack_m;
  fsrc_pkg::reg_data_t   exp_rdata;
  // Shadow of the output register
  logic                  exp_valid;
  fsrc_pkg::beat_t       exp_data;
  logic [32:0]           next_phase;
  logic                  start_m;
  logic                  carry_m;
  logic                  slot_free;
  logic                  exp_ready;
  logic                  take_m;
  logic                  extra_m;
  logic                  step_now;

  initial begin
    errors = 0;
    passes = 0;
  end

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    errors++;
    $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
  endtask

  // Masked channels get the fill sample, the rest repeat the previous beat
  function automatic fsrc_pkg::beat_t inserted_beat(input fsrc_pkg::beat_t prev,
                                                    input fsrc_pkg::chan_mask_t mask);
    fsrc_pkg::beat_t b;
    b = prev;
    for (int ch = 0; ch < fsrc_pkg::NUM_CHANNELS; ch++) begin
      if (mask[ch]) begin
        b[ch*fsrc_pkg::SAMPLE_WIDTH +: fsrc_pkg::SAMPLE_WIDTH] = fsrc_pkg::FILL_SAMPLE;
      end
    end
    return b;
  endfunction

  function automatic fsrc_pkg::reg_data_t expected_read(input fsrc_pkg::reg_addr_t addr);
    case (addr)
      fsrc_pkg::ADDR_VERSION:      return fsrc_pkg::CORE_VERSION;
      fsrc_pkg::ADDR_MAGIC:        return fsrc_pkg::CORE_MAGIC;
      fsrc_pkg::ADDR_CONTROL:      return {30'd0, ext_trig_m, enable_m};
      fsrc_pkg::ADDR_CONV_MASK:    return {28'd0, mask_m};
      fsrc_pkg::ADDR_STEP:         return step_m;
      fsrc_pkg::ADDR_SET_PHASE:    return set_phase_m;
      fsrc_pkg::ADDR_STATUS:       return {31'd0, run_m};
      fsrc_pkg::ADDR_INSERT_COUNT: return count_m;
      default:                     return '0;
    endcase
  endfunction

  // *******************************************************************
  // Model
  // *******************************************************************

  // The phase wraps past 2^32 exactly when an extra beat is due
  assign next_phase = {1'b0, phase_m} + {1'b0, step_m};
  assign carry_m    = run_m && next_phase[32];
  assign start_m    = start_wr_m || (start && ext_trig_m);
  assign slot_free  = !exp_valid || m_axis_ready;
  assign exp_ready  = ready_q_m && slot_free && (!enable_m || (run_m && !carry_m));
  assign take_m     = s_axis_valid && exp_ready;
  assign extra_m    = slot_free && enable_m && run_m && carry_m;
  assign step_now   = enable_m && run_m && (extra_m || take_m);

  always_ff @(posedge clk) begin
    if (reset) begin
      {enable_m, ext_trig_m, start_wr_m, stop_m, phase_load_m} <= '0;
      {run_m, ready_q_m, wack_m, rack_m, exp_valid} <= '0;
      mask_m      <= '0;
      step_m      <= '0;
      set_phase_m <= '0;
      phase_m     <= '0;
      count_m     <= '0;
    end else begin
      start_wr_m   <= up_wreq && up_waddr == fsrc_pkg::ADDR_START && up_wdata[0];
      stop_m       <= up_wreq && up_waddr == fsrc_pkg::ADDR_STOP && up_wdata[0];
      phase_load_m <= up_wreq && up_waddr == fsrc_pkg::ADDR_PHASE_LOAD && up_wdata[0];
      if (up_wreq && up_waddr == fsrc_pkg::ADDR_CONTROL) begin
        enable_m   <= up_wdata[0];
        ext_trig_m <= up_wdata[1];
      end
      if (up_wreq && up_waddr == fsrc_pkg::ADDR_CONV_MASK) mask_m <= up_wdata[3:0];
      if (up_wreq && up_waddr == fsrc_pkg::ADDR_STEP) step_m <= up_wdata;
      if (up_wreq && up_waddr == fsrc_pkg::ADDR_SET_PHASE) set_phase_m <= up_wdata;
      wack_m    <= up_wreq;
      rack_m    <= up_rreq;
      ready_q_m <= 1'b1;
      // Stop and a dropped enable both end the run
      if (!run_m) begin
        run_m <= start_m && enable_m;
      end else if (stop_m || !enable_m) begin
        run_m <= 1'b0;
      end
      if (phase_load_m) begin
        phase_m <= set_phase_m;
      end else if (step_now) begin
        phase_m <= next_phase[31:0];
      end
      if (start_m) begin
        count_m <= '0;
      end else if (step_now && carry_m) begin
        count_m <= count_m + 1;
      end
      if (slot_free) exp_valid <= extra_m || take_m;
    end
  end

  always_ff @(posedge clk) begin
    if (extra_m) begin
      exp_data <= inserted_beat(exp_data, mask_m);
    end else if (take_m) begin
      exp_data <= s_axis_data;
    end
    if (up_rreq) exp_rdata <= expected_read(up_raddr);
  end

  // *******************************************************************
  // Port checks
  // *******************************************************************

  assert property (@(posedge clk) disable iff (reset) s_axis_ready == exp_ready) passes++;
    else report_mismatch("s_axis_ready", $sampled(exp_ready), $sampled(s_axis_ready));
  assert property (@(posedge clk) disable iff (reset) m_axis_valid == exp_valid) passes++;
    else report_mismatch("m_axis_valid", $sampled(exp_valid), $sampled(m_axis_valid));
  assert property (@(posedge clk) disable iff (reset) exp_valid |-> m_axis_data == exp_data)
    passes++;
    else report_mismatch("m_axis_data", $sampled(exp_data), $sampled(m_axis_data));
  assert property (@(posedge clk) disable iff (reset) up_wack == wack_m) passes++;
    else report_mismatch("up_wack", $sampled(wack_m), $sampled(up_wack));
  assert property (@(posedge clk) disable iff (reset) up_rack == rack_m) passes++;
    else report_mismatch("up_rack", $sampled(rack_m), $sampled(up_rack));
  assert property (@(posedge clk) disable iff (reset) rack_m |-> up_rdata == exp_rdata)
    passes++;
    else report_mismatch("up_rdata", $sampled(exp_rdata), $sampled(up_rdata));

endmodule

//--- verification/fsrc_tx_tb.sv
// *********************************************************************
// Converter testbench
// Drives registers, the start pin and both streams through register
// access, bypass, run control, insertion, back-pressure and zero step
// *********************************************************************

module fsrc_tx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD      = 4;
  localparam int          TOTAL_BEATS     = 100;
  localparam int          WATCHDOG_CYCLES = TOTAL_BEATS * 8 + 1000;
  localparam logic [31:0] RNG_SEED        = 32'haf15b94c;

  logic                 clk;
  logic                 reset;
  logic                 start;
  logic                 s_axis_valid;
  logic                 s_axis_ready;
  fsrc_pkg::beat_t      s_axis_data;
  logic                 m_axis_valid;
  logic                 m_axis_ready;
  fsrc_pkg::beat_t      m_axis_data;
  logic                 up_wreq;
  fsrc_pkg::reg_addr_t  up_waddr;
  fsrc_pkg::reg_data_t  up_wdata;
  logic                 up_wack;
  logic                 up_rreq;
  fsrc_pkg::reg_addr_t  up_raddr;
  fsrc_pkg::reg_data_t  up_rdata;
  logic                 up_rack;
  int                   error_count;
  int                   pass_count;
  // Beats requested from the stream driver and beats it has presented
  int                   send_target = 0;
  int                   sent_count = 0;
  logic                 stall_en = 1'b0;
  logic [31:0]          rng_state = RNG_SEED;

  fsrc_tx dut_i (.*);

  fsrc_tx_checks checks_i (.*, .errors(error_count), .passes(pass_count));

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // Xorshift generator for sample data and ready patterns
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // *******************************************************************
  // Stream driver
  // *******************************************************************

  // A beat stays on the input until the cycle after it was taken
  initial begin : stream_driver
    logic taken;
    taken = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (taken || !s_axis_valid) begin
        if (sent_count < send_target) begin
          s_axis_valid = 1'b1;
          s_axis_data  = {next_random(), next_random()};
          sent_count++;
        end else begin
          s_axis_valid = 1'b0;
        end
      end
      m_axis_ready = stall_en ? (next_random() % 3 != 0) : 1'b1;
      #1;
      taken = s_axis_valid && s_axis_ready;
    end
  end

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_reg(input fsrc_pkg::reg_addr_t addr, input fsrc_pkg::reg_data_t data);
    up_wreq  = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    idle(1);
    up_wreq = 1'b0;
    while (!up_wack) idle(1);
  endtask

  task automatic read_reg(input fsrc_pkg::reg_addr_t addr);
    up_rreq  = 1'b1;
    up_raddr = addr;
    idle(1);
    up_rreq = 1'b0;
    while (!up_rack) idle(1);
  endtask

  task automatic pulse_start_pin();
    start = 1'b1;
    idle(1);
    start = 1'b0;
  endtask

  // Waits until every queued beat has been taken and the output is empty
  task automatic wait_stream_idle();
    do begin
      @(posedge clk);
      #2;
    end while (sent_count != send_target || s_axis_valid || m_axis_valid);
    idle(1);
  endtask

  task automatic send_beats(input int count);
    send_target <= send_target + count;
    wait_stream_idle();
  endtask

  // *******************************************************************
  // Test sequence
  // *******************************************************************

  initial begin : main_sequence
    reset        = 1'b1;
    start        = 1'b0;
    s_axis_valid = 1'b0;
    s_axis_data  = '0;
    m_axis_ready = 1'b1;
    up_wreq      = 1'b0;
    up_waddr     = '0;
    up_wdata     = '0;
    up_rreq      = 1'b0;
    up_raddr     = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    idle(2);

    // Identification words, writable settings and an unmapped address
    read_reg(fsrc_pkg::ADDR_VERSION);
    read_reg(fsrc_pkg::ADDR_MAGIC);
    write_reg(fsrc_pkg::ADDR_CONV_MASK, 32'h5);
    read_reg(fsrc_pkg::ADDR_CONV_MASK);
    write_reg(fsrc_pkg::ADDR_STEP, 32'h4000_0000);
    read_reg(fsrc_pkg::ADDR_STEP);
    write_reg(fsrc_pkg::ADDR_SET_PHASE, 32'h1234_5678);
    read_reg(fsrc_pkg::ADDR_SET_PHASE);
    write_reg(fsrc_pkg::ADDR_CONTROL, 32'h2);
    read_reg(fsrc_pkg::ADDR_CONTROL);
    read_reg(8'h3F);

    // Bypass with the converter disabled
    write_reg(fsrc_pkg::ADDR_CONTROL, 32'h0);
    send_beats(16);

    // Enabled but stopped, the pin is ignored until ext_trig_en is set
    write_reg(fsrc_pkg::ADDR_CONTROL, 32'h1);
    send_target <= send_target + 4;
    idle(8);
    pulse_start_pin();
    idle(4);
    read_reg(fsrc_pkg::ADDR_STATUS);
    write_reg(fsrc_pkg::ADDR_CONTROL, 32'h3);
    pulse_start_pin();
    wait_stream_idle();
    read_reg(fsrc_pkg::ADDR_STATUS);
    // The run state follows the stop pulse one cycle after the write
    write_reg(fsrc_pkg::ADDR_STOP, 32'h1);
    idle(1);
    read_reg(fsrc_pkg::ADDR_STATUS);
    write_reg(fsrc_pkg::ADDR_CONTROL, 32'h1);
    write_reg(fsrc_pkg::ADDR_START, 32'h1);
    idle(1);
    read_reg(fsrc_pkg::ADDR_STATUS);
    write_reg(fsrc_pkg::ADDR_STOP, 32'h1);

    // Quarter step from phase zero inserts every fourth beat
    write_reg(fsrc_pkg::ADDR_SET_PHASE, 32'h0);
    write_reg(fsrc_pkg::ADDR_PHASE_LOAD, 32'h1);
    write_reg(fsrc_pkg::ADDR_STEP, 32'h4000_0000);
    write_reg(fsrc_pkg::ADDR_CONV_MASK, 32'h5);
    write_reg(fsrc_pkg::ADDR_START, 32'h1);
    send_beats(24);
    read_reg(fsrc_pkg::ADDR_INSERT_COUNT);
    write_reg(fsrc_pkg::ADDR_STOP, 32'h1);

    // Random output stalls during a run
    stall_en <= 1'b1;
    write_reg(fsrc_pkg::ADDR_START, 32'h1);
    send_beats(40);
    read_reg(fsrc_pkg::ADDR_INSERT_COUNT);
    stall_en <= 1'b0;
    write_reg(fsrc_pkg::ADDR_STOP, 32'h1);

    // Zero step never inserts
    write_reg(fsrc_pkg::ADDR_STEP, 32'h0);
    write_reg(fsrc_pkg::ADDR_START, 32'h1);
    send_beats(16);
    read_reg(fsrc_pkg::ADDR_INSERT_COUNT);
    write_reg(fsrc_pkg::ADDR_STOP, 32'h1);
    idle(1);
    read_reg(fsrc_pkg::ADDR_STATUS);
    idle(4);

    $display("Checks passed: %0d, checks failed: %0d", pass_count, error_count);
    if (error_count == 0 && pass_count > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
